//--- build.f
+incdir+design
design/xbar_pkg.sv
design/rr_sched.sv
design/xbar_cfg.sv
design/ar_router.sv
design/r_router.sv
design/rd_xbar_top.sv
verif/rd_xbar_tb.sv

//--- run.sh
#!/bin/sh
# compiles the read crossbar with its testbench, runs it and checks the log
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -f build.f --top-module rd_xbar_tb \
   -o rd_xbar_sim > build.log 2>&1 &&
./obj_dir/rd_xbar_sim > sim.log 2>&1 &&
grep -q "No errors" sim.log &&
echo "simulation passed" ||
{ echo "simulation failed, see build.log and sim.log"; exit 1; }

//--- verif/rd_xbar_tb.sv
//********************
// directed testbench of the read crossbar
// inputs change on the falling edge and handshakes are scored 1 ns later
// a port register holds one item, so each scoreboard queue is strict FIFO
// expected routing follows the interleave, compaction and ID rules
//********************

`timescale 1ns/1ns

`include "xbar_defines.svh"

module rd_xbar_tb;

   localparam int NS = `XBAR_NUM_SRC;
   localparam int NM = `XBAR_NUM_MEM;
   localparam int LB = `XBAR_LINE_BITS;
   // reset, then each test in the order it runs
   localparam int RUN_CYCLES   = 16 + 4 + 20 + 80 + 60 + 80 + 500;
   localparam int LIMIT_CYCLES = RUN_CYCLES * 2 + 1000;

   logic                           clk;
   logic                           rstn;
   xbar_pkg::ar_req_t [NS-1:0]     src_ar;
   logic              [NS-1:0]     src_ar_valid;
   logic              [NS-1:0]     src_ar_ready;
   xbar_pkg::r_beat_t [NS-1:0]     src_r;
   logic              [NS-1:0]     src_r_valid;
   logic              [NS-1:0]     src_r_ready;
   xbar_pkg::ar_req_t [NM-1:0]     mem_ar;
   logic              [NM-1:0]     mem_ar_valid;
   logic              [NM-1:0]     mem_ar_ready;
   xbar_pkg::r_beat_t [NM-1:0]     mem_r;
   logic              [NM-1:0]     mem_r_valid;
   logic              [NM-1:0]     mem_r_ready;
   logic                           cfg_wr;
   logic              [1:0]        cfg_mode;
   logic                           cfg_err;

   // items waiting to be offered, and items expected at each destination
   xbar_pkg::ar_req_t   src_q  [NS][$];
   xbar_pkg::r_beat_t   mem_q  [NM][$];
   xbar_pkg::ar_req_t   exp_ar [NM][$];
   xbar_pkg::r_beat_t   exp_r  [NS][$];
   int                  accept_log[$];
   int                  ar_seen [NM];
   int                  ar_done;
   int                  r_done;
   int                  err_cnt;
   int                  n_tests;
   logic [NM-1:0]       hold_ar;
   bit                  rand_mem_rdy;
   bit                  rand_src_rdy;
   xbar_pkg::mem_mode_e exp_mode;

   rd_xbar_top i_rd_xbar_top (.*);

   initial begin
      clk = 1'b0;
      forever #20 clk = ~clk;
   end

   function automatic int target_of(input xbar_pkg::axi_addr_t addr,
                                    input xbar_pkg::mem_mode_e m);
      int port;
      if (m == xbar_pkg::MODE_ONE) begin
         port = 0;
      end else if (m == xbar_pkg::MODE_TWO) begin
         port = int'(addr[6]);
      end else begin
         port = int'(addr[7:6]);
      end
      return port;
   endfunction

   function automatic xbar_pkg::axi_addr_t expect_addr(input xbar_pkg::axi_addr_t addr,
                                                       input xbar_pkg::mem_mode_e m);
      xbar_pkg::axi_addr_t res;
      res = addr >> ((m == xbar_pkg::MODE_ONE) ? 0 : (m == xbar_pkg::MODE_TWO) ? 1 : 2);
      res[LB-1:0] = '0;
      return res;
   endfunction

   // sel lands on address bits 7:6, the rest is random
   function automatic xbar_pkg::ar_req_t make_req(input int sel);
      xbar_pkg::ar_req_t req;
      req.id        = 8'($urandom);
      req.addr      = $urandom;
      req.addr[7:6] = 2'(sel);
      req.len       = 8'($urandom);
      return req;
   endfunction

   function automatic xbar_pkg::r_beat_t make_beat(input int dst);
      xbar_pkg::r_beat_t beat;
      beat.id   = {2'(dst), 6'($urandom)};
      beat.data = {$urandom, $urandom};
      beat.resp = 2'($urandom);
      beat.last = 1'($urandom);
      return beat;
   endfunction

   task automatic score_requests();
      xbar_pkg::ar_req_t req;
      int tgt;
      for (int m = 0; m < NM; m++) begin
         if (mem_ar_valid[m]) begin
            if (exp_ar[m].size() == 0) begin
               $display("controller %0d shows a request that no source sent", m);
               err_cnt++;
            end else begin
               if (mem_ar[m] !== exp_ar[m][0]) begin
                  $display("ERR mem_ar[%0d] got %h expected %h", m, mem_ar[m], exp_ar[m][0]);
                  err_cnt++;
               end
               if (mem_ar_ready[m]) begin
                  void'(exp_ar[m].pop_front());
                  ar_seen[m]++;
                  ar_done++;
               end
            end
         end else if (exp_ar[m].size() != 0) begin
            $display("controller %0d shows no request one cycle after acceptance", m);
            err_cnt++;
         end
      end
      for (int s = 0; s < NS; s++) begin
         if (src_ar_valid[s] && src_ar_ready[s]) begin
            req      = src_q[s].pop_front();
            tgt      = target_of(req.addr, exp_mode);
            req.addr = expect_addr(req.addr, exp_mode);
            exp_ar[tgt].push_back(req);
            accept_log.push_back(s);
            if (exp_ar[tgt].size() > 1) begin
               $display("controller %0d took a request while its register was full", tgt);
               err_cnt++;
            end
         end
      end
   endtask

   task automatic score_beats();
      xbar_pkg::r_beat_t beat;
      int dst;
      for (int s = 0; s < NS; s++) begin
         if (src_r_valid[s]) begin
            if (exp_r[s].size() == 0) begin
               $display("source %0d shows a beat that no controller sent", s);
               err_cnt++;
            end else begin
               if (src_r[s] !== exp_r[s][0]) begin
                  $display("ERR src_r[%0d] got %h expected %h", s, src_r[s], exp_r[s][0]);
                  err_cnt++;
               end
               if (src_r_ready[s]) begin
                  void'(exp_r[s].pop_front());
                  r_done++;
               end
            end
         end else if (exp_r[s].size() != 0) begin
            $display("source %0d shows no beat one cycle after acceptance", s);
            err_cnt++;
         end
      end
      for (int m = 0; m < NM; m++) begin
         if (mem_r_valid[m] && mem_r_ready[m]) begin
            beat = mem_q[m].pop_front();
            dst  = int'(beat.id[`XBAR_ID_W-1 -: 2]);
            exp_r[dst].push_back(beat);
            if (exp_r[dst].size() > 1) begin
               $display("source %0d took a beat while its register was full", dst);
               err_cnt++;
            end
         end
      end
   endtask

   // offers the pending items each cycle and scores what the DUT did with them
   initial begin : bus
      src_ar       = '0;
      src_ar_valid = '0;
      src_r_ready  = '0;
      mem_ar_ready = '0;
      mem_r        = '0;
      mem_r_valid  = '0;
      forever begin
         @(negedge clk);
         for (int s = 0; s < NS; s++) begin
            src_ar_valid[s] = (src_q[s].size() != 0);
            if (src_ar_valid[s]) begin
               src_ar[s] = src_q[s][0];
            end
            src_r_ready[s] = rand_src_rdy ? 1'($urandom) : 1'b1;
         end
         for (int m = 0; m < NM; m++) begin
            mem_r_valid[m] = (mem_q[m].size() != 0);
            if (mem_r_valid[m]) begin
               mem_r[m] = mem_q[m][0];
            end
            mem_ar_ready[m] = hold_ar[m] ? 1'b0 : rand_mem_rdy ? 1'($urandom) : 1'b1;
         end
         #1;
         if (rstn) begin
            score_requests();
            score_beats();
         end
      end
   end

   // a quiet point in the cycle, after the scoring and before the next drive
   task automatic sync_point();
      @(negedge clk);
      #5;
   endtask

   task automatic wait_idle();
      bit busy;
      busy = 1'b1;
      while (busy) begin
         sync_point();
         busy = 1'b0;
         for (int i = 0; i < NS; i++) begin
            if (src_q[i].size() != 0 || exp_r[i].size() != 0) begin
               busy = 1'b1;
            end
         end
         for (int i = 0; i < NM; i++) begin
            if (mem_q[i].size() != 0 || exp_ar[i].size() != 0) begin
               busy = 1'b1;
            end
         end
      end
   endtask

   task automatic write_mode(input logic [1:0] enc);
      @(negedge clk);
      cfg_wr   = 1'b1;
      cfg_mode = enc;
      @(negedge clk);
      cfg_wr = 1'b0;
      if (enc != 2'd3) begin
         exp_mode = xbar_pkg::mem_mode_e'(enc);
      end
   endtask

   // compares the per-controller request counts, then clears them
   task automatic check_spread(input int c0, input int c1, input int c2, input int c3);
      int want [NM];
      want = '{c0, c1, c2, c3};
      for (int m = 0; m < NM; m++) begin
         if (ar_seen[m] != want[m]) begin
            $display("controller %0d received %0d requests, expected %0d", m, ar_seen[m],
                     want[m]);
            err_cnt++;
         end
         ar_seen[m] = 0;
      end
   endtask

   task automatic report(input string name, input int start);
      $display("%s: %0d failed checks", name, err_cnt - start);
      n_tests++;
   endtask

   task automatic check_reset_state();
      int start;
      start = err_cnt;
      sync_point();
      if (mem_ar_valid !== '0) begin
         $display("ERR mem_ar_valid got %h expected %h", mem_ar_valid, 4'h0);
         err_cnt++;
      end
      if (src_r_valid !== '0) begin
         $display("ERR src_r_valid got %h expected %h", src_r_valid, 4'h0);
         err_cnt++;
      end
      if (cfg_err !== 1'b0) begin
         $display("ERR cfg_err got %h expected %h", cfg_err, 1'b0);
         err_cnt++;
      end
      report("reset state", start);
   endtask

   task automatic route_four_way();
      int start;
      start = err_cnt;
      sync_point();
      for (int s = 0; s < NS; s++) begin
         src_q[s].push_back(make_req((s + 1) % NM));
      end
      wait_idle();
      check_spread(1, 1, 1, 1);
      report("four-way interleave", start);
   endtask

   task automatic send_all_selectors();
      sync_point();
      for (int s = 0; s < NS; s++) begin
         src_q[s].push_back(make_req(s));
      end
      wait_idle();
   endtask

   task automatic change_modes();
      int start;
      start = err_cnt;
      write_mode(2'd1);
      if (cfg_err !== 1'b0) begin
         $display("ERR cfg_err got %h expected %h", cfg_err, 1'b0);
         err_cnt++;
      end
      send_all_selectors();
      check_spread(2, 2, 0, 0);
      write_mode(2'd0);
      send_all_selectors();
      check_spread(4, 0, 0, 0);
      write_mode(2'd3);
      if (cfg_err !== 1'b1) begin
         $display("ERR cfg_err got %h expected %h", cfg_err, 1'b1);
         err_cnt++;
      end
      send_all_selectors();
      check_spread(4, 0, 0, 0);
      write_mode(2'd2);
      report("mode changes", start);
   endtask

   task automatic contend_one_port();
      int start;
      logic [NS-1:0] seen;
      start = err_cnt;
      sync_point();
      accept_log.delete();
      hold_ar[1] = 1'b1;
      for (int rep = 0; rep < 2; rep++) begin
         for (int s = 0; s < NS; s++) begin
            src_q[s].push_back(make_req(1));
         end
      end
      repeat (10) @(negedge clk);
      #5;
      if (ar_seen[1] != 0) begin
         $display("controller 1 completed requests while its ready was low");
         err_cnt++;
      end
      hold_ar[1] = 1'b0;
      wait_idle();
      check_spread(0, 8, 0, 0);
      if (accept_log.size() != 8) begin
         $display("%0d requests accepted, expected 8", accept_log.size());
         err_cnt++;
      end else begin
         for (int w = 0; w < 2; w++) begin
            seen = '0;
            for (int i = 0; i < NS; i++) begin
               seen[accept_log[w * NS + i]] = 1'b1;
            end
            if (seen != '1) begin
               $display("a source was served twice before every source was served");
               err_cnt++;
            end
         end
      end
      report("contention under back-pressure", start);
   endtask

   task automatic route_responses();
      int start;
      int done0;
      start = err_cnt;
      done0 = r_done;
      sync_point();
      rand_src_rdy = 1'b1;
      for (int m = 0; m < NM; m++) begin
         for (int k = 0; k < 4; k++) begin
            mem_q[m].push_back(make_beat(int'($urandom_range(NS - 1))));
         end
      end
      wait_idle();
      rand_src_rdy = 1'b0;
      if (r_done - done0 != 16) begin
         $display("%0d beats delivered, expected 16", r_done - done0);
         err_cnt++;
      end
      report("response routing", start);
   endtask

   task automatic run_random_traffic();
      int start;
      int ar0;
      int r0;
      int sel;
      int want [NM];
      start = err_cnt;
      ar0   = ar_done;
      r0    = r_done;
      want  = '{default: 0};
      sync_point();
      rand_mem_rdy = 1'b1;
      rand_src_rdy = 1'b1;
      for (int i = 0; i < 100; i++) begin
         sel = int'($urandom_range(3));
         // in four-way mode the selector bits name the controller
         want[sel]++;
         src_q[$urandom_range(NS - 1)].push_back(make_req(sel));
         mem_q[$urandom_range(NM - 1)].push_back(make_beat(int'($urandom_range(NS - 1))));
      end
      wait_idle();
      rand_mem_rdy = 1'b0;
      rand_src_rdy = 1'b0;
      if (ar_done - ar0 != 100 || r_done - r0 != 100) begin
         $display("%0d requests and %0d beats delivered, expected 100 each", ar_done - ar0,
                  r_done - r0);
         err_cnt++;
      end
      check_spread(want[0], want[1], want[2], want[3]);
      report("random mixed traffic", start);
   endtask

   initial begin
      void'($urandom(32'h80f1_5d38));
      rstn         = 1'b0;
      cfg_wr       = 1'b0;
      cfg_mode     = 2'd2;
      exp_mode     = xbar_pkg::MODE_FOUR;
      hold_ar      = '0;
      rand_mem_rdy = 1'b0;
      rand_src_rdy = 1'b0;
      err_cnt      = 0;
      n_tests      = 0;
      ar_done      = 0;
      r_done       = 0;
      repeat (16) @(negedge clk);
      rstn = 1'b1;
      check_reset_state();
      route_four_way();
      change_modes();
      contend_one_port();
      route_responses();
      run_random_traffic();
      $display("%0d tests run, %0d failed checks", n_tests, err_cnt);
      if (err_cnt == 0) begin
         $display("No errors");
      end else begin
         $display("Errors found");
      end
      $finish;
   end

   initial begin
      repeat (LIMIT_CYCLES) @(posedge clk);
      $display("timeout after %0d cycles, traffic did not drain", LIMIT_CYCLES);
      $display("Errors found");
      $finish;
   end

endmodule

//--- design/rd_xbar_top.sv
//********************
// read half of the memory-side AXI crossbar
// four sources to four controllers, write channels are not carried
// no reordering across controllers, one cycle per direction
//********************

`timescale 1ns/1ns

`include "xbar_defines.svh"

module rd_xbar_top (
   input  logic                                     clk,
   input  logic                                     rstn,

   input  xbar_pkg::ar_req_t   [`XBAR_NUM_SRC-1:0]  src_ar,
   input  logic                [`XBAR_NUM_SRC-1:0]  src_ar_valid,
   output logic                [`XBAR_NUM_SRC-1:0]  src_ar_ready,
   output xbar_pkg::r_beat_t   [`XBAR_NUM_SRC-1:0]  src_r,
   output logic                [`XBAR_NUM_SRC-1:0]  src_r_valid,
   input  logic                [`XBAR_NUM_SRC-1:0]  src_r_ready,

   output xbar_pkg::ar_req_t   [`XBAR_NUM_MEM-1:0]  mem_ar,
   output logic                [`XBAR_NUM_MEM-1:0]  mem_ar_valid,
   input  logic                [`XBAR_NUM_MEM-1:0]  mem_ar_ready,
   input  xbar_pkg::r_beat_t   [`XBAR_NUM_MEM-1:0]  mem_r,
   input  logic                [`XBAR_NUM_MEM-1:0]  mem_r_valid,
   output logic                [`XBAR_NUM_MEM-1:0]  mem_r_ready,

   input  logic                                     cfg_wr,
   input  logic                [1:0]                cfg_mode,
   output logic                                     cfg_err
);

   xbar_pkg::mem_mode_e mode;

   xbar_cfg i_xbar_cfg (
      .clk     (clk),
      .rstn    (rstn),
      .cfg_wr  (cfg_wr),
      .cfg_mode(cfg_mode),
      .mode    (mode),
      .cfg_err (cfg_err)
   );

   ar_router i_ar_router (
      .clk         (clk),
      .rstn        (rstn),
      .mode        (mode),
      .src_ar      (src_ar),
      .src_ar_valid(src_ar_valid),
      .src_ar_ready(src_ar_ready),
      .mem_ar      (mem_ar),
      .mem_ar_valid(mem_ar_valid),
      .mem_ar_ready(mem_ar_ready)
   );

   // responses are routed by ID alone and ignore the mode
   r_router i_r_router (
      .clk        (clk),
      .rstn       (rstn),
      .mem_r      (mem_r),
      .mem_r_valid(mem_r_valid),
      .mem_r_ready(mem_r_ready),
      .src_r      (src_r),
      .src_r_valid(src_r_valid),
      .src_r_ready(src_r_ready)
   );

endmodule

//--- design/r_router.sv
//********************
// read data router from memory controllers back to sources
// the destination is the top XBAR_PORT_W bits of the beat ID
// beats pass unaltered through one register stage per source
// beats from one controller to one source keep their order
//********************

`timescale 1ns/1ns

`include "xbar_defines.svh"

module r_router (
   input  logic                                     clk,
   input  logic                                     rstn,
   input  xbar_pkg::r_beat_t   [`XBAR_NUM_MEM-1:0]  mem_r,
   input  logic                [`XBAR_NUM_MEM-1:0]  mem_r_valid,
   output logic                [`XBAR_NUM_MEM-1:0]  mem_r_ready,
   output xbar_pkg::r_beat_t   [`XBAR_NUM_SRC-1:0]  src_r,
   output logic                [`XBAR_NUM_SRC-1:0]  src_r_valid,
   input  logic                [`XBAR_NUM_SRC-1:0]  src_r_ready
);

   localparam int NS = `XBAR_NUM_SRC;
   localparam int NM = `XBAR_NUM_MEM;
   localparam int PW = `XBAR_PORT_W;

   logic [NM-1:0][PW-1:0] dst;
   logic [NS-1:0][NM-1:0] sched_in;
   logic [NS-1:0][PW-1:0] sched_out;
   logic [NS-1:0]         can_take;
   logic [NS-1:0]         take;

   always_comb begin
      for (int m = 0; m < NM; m++) begin
         dst[m] = mem_r[m].id[`XBAR_ID_W-1 -: PW];
      end
      for (int s = 0; s < NS; s++) begin
         for (int m = 0; m < NM; m++) begin
            sched_in[s][m] = mem_r_valid[m] & (dst[m] == PW'(s));
         end
         can_take[s] = ~src_r_valid[s] | src_r_ready[s];
         take[s]     = can_take[s] & (|sched_in[s]);
      end
      for (int m = 0; m < NM; m++) begin
         mem_r_ready[m] = mem_r_valid[m] & can_take[dst[m]] &
                          (sched_out[dst[m]] == PW'(m));
      end
   end

   for (genvar s = 0; s < NS; s++) begin : g_src
      rr_sched #(
         .IN_WIDTH (NM),
         .OUT_WIDTH(PW)
      ) i_rr_sched (
         .clk    (clk),
         .rstn   (rstn),
         .req    (sched_in[s]),
         .advance(take[s]),
         .grant  (sched_out[s])
      );

      a_r_stable : assert property (@(posedge clk) disable iff (!rstn)
         (src_r_valid[s] && !src_r_ready[s]) |=> (src_r_valid[s] && $stable(src_r[s])));
   end

   always_ff @(posedge clk) begin
      if (!rstn) begin
         src_r_valid <= '0;
      end else begin
         for (int s = 0; s < NS; s++) begin
            if (take[s]) begin
               src_r_valid[s] <= 1'b1;
            end else if (src_r_ready[s]) begin
               src_r_valid[s] <= 1'b0;
            end
         end
      end
   end

   always_ff @(posedge clk) begin
      for (int s = 0; s < NS; s++) begin
         if (take[s]) begin
            src_r[s] <= mem_r[sched_out[s]];
         end
      end
   end

endmodule

//--- design/ar_router.sv
//********************
// read request router from sources to memory controllers
// the controller is picked by line interleaving on address bits 7:6
// the outgoing address drops the selector bits and clears the line offset
// one register stage per controller, latency of exactly one cycle
//********************

`timescale 1ns/1ns

`include "xbar_defines.svh"

module ar_router (
   input  logic                                       clk,
   input  logic                                       rstn,
   input  xbar_pkg::mem_mode_e                        mode,
   input  xbar_pkg::ar_req_t   [`XBAR_NUM_SRC-1:0]    src_ar,
   input  logic                [`XBAR_NUM_SRC-1:0]    src_ar_valid,
   output logic                [`XBAR_NUM_SRC-1:0]    src_ar_ready,
   output xbar_pkg::ar_req_t   [`XBAR_NUM_MEM-1:0]    mem_ar,
   output logic                [`XBAR_NUM_MEM-1:0]    mem_ar_valid,
   input  logic                [`XBAR_NUM_MEM-1:0]    mem_ar_ready
);

   localparam int NS = `XBAR_NUM_SRC;
   localparam int NM = `XBAR_NUM_MEM;
   localparam int PW = `XBAR_PORT_W;
   localparam int LB = `XBAR_LINE_BITS;

   logic [NS-1:0][PW-1:0] src_port;
   logic [NM-1:0][NS-1:0] sched_in;
   logic [NM-1:0][PW-1:0] sched_out;
   logic [NM-1:0]         can_take;
   logic [NM-1:0]         take;

   // remove the selector bits, then clear the line offset
   function automatic xbar_pkg::axi_addr_t compact(input xbar_pkg::axi_addr_t addr,
                                                   input xbar_pkg::mem_mode_e m);
      xbar_pkg::axi_addr_t shifted;
      case (m)
         xbar_pkg::MODE_ONE: shifted = addr;
         xbar_pkg::MODE_TWO: shifted = addr >> 1;
         default:            shifted = addr >> 2;
      endcase
      return {shifted[`XBAR_ADDR_W-1:LB], {LB{1'b0}}};
   endfunction

   always_comb begin
      for (int s = 0; s < NS; s++) begin
         case (mode)
            xbar_pkg::MODE_ONE: src_port[s] = '0;
            xbar_pkg::MODE_TWO: src_port[s] = PW'(src_ar[s].addr[LB]);
            default:            src_port[s] = src_ar[s].addr[LB +: PW];
         endcase
      end
      for (int m = 0; m < NM; m++) begin
         for (int s = 0; s < NS; s++) begin
            sched_in[m][s] = src_ar_valid[s] & (src_port[s] == PW'(m));
         end
         // the register is free or drains this cycle
         can_take[m] = ~mem_ar_valid[m] | mem_ar_ready[m];
         take[m]     = can_take[m] & (|sched_in[m]);
      end
      // port has room, we are valid and the scheduler chose us
      for (int s = 0; s < NS; s++) begin
         src_ar_ready[s] = src_ar_valid[s] & can_take[src_port[s]] &
                           (sched_out[src_port[s]] == PW'(s));
      end
   end

   for (genvar m = 0; m < NM; m++) begin : g_mem
      rr_sched #(
         .IN_WIDTH (NS),
         .OUT_WIDTH(PW)
      ) i_rr_sched (
         .clk    (clk),
         .rstn   (rstn),
         .req    (sched_in[m]),
         .advance(take[m]),
         .grant  (sched_out[m])
      );

      a_ar_stable : assert property (@(posedge clk) disable iff (!rstn)
         (mem_ar_valid[m] && !mem_ar_ready[m]) |=> (mem_ar_valid[m] && $stable(mem_ar[m])));
   end

   always_ff @(posedge clk) begin
      if (!rstn) begin
         mem_ar_valid <= '0;
      end else begin
         for (int m = 0; m < NM; m++) begin
            if (take[m]) begin
               mem_ar_valid[m] <= 1'b1;
            end else if (mem_ar_ready[m]) begin
               mem_ar_valid[m] <= 1'b0;
            end
         end
      end
   end

   always_ff @(posedge clk) begin
      for (int m = 0; m < NM; m++) begin
         if (take[m]) begin
            mem_ar[m].id   <= src_ar[sched_out[m]].id;
            mem_ar[m].len  <= src_ar[sched_out[m]].len;
            mem_ar[m].addr <= compact(src_ar[sched_out[m]].addr, mode);
         end
      end
   end

endmodule

//--- design/xbar_cfg.sv
//********************
// run-time interleave mode register
// resets to four active controllers
// a write of encoding 3 is dropped and sets a sticky error until reset
//********************

`timescale 1ns/1ns

module xbar_cfg (
   input  logic                clk,
   input  logic                rstn,
   input  logic                cfg_wr,
   input  logic [1:0]          cfg_mode,
   output xbar_pkg::mem_mode_e mode,
   output logic                cfg_err
);

   logic illegal;

   assign illegal = (cfg_mode == 2'd3);

   always_ff @(posedge clk) begin
      if (!rstn) begin
         mode    <= xbar_pkg::MODE_FOUR;
         cfg_err <= 1'b0;
      end else if (cfg_wr) begin
         if (illegal) begin
            cfg_err <= 1'b1;
         end else begin
            mode <= xbar_pkg::mem_mode_e'(cfg_mode);
         end
      end
   end

endmodule

//--- design/rr_sched.sv
//********************
// round-robin pick of one requester per cycle
// grant is combinational and only meaningful while req is not empty
// advance must only be raised when the granted requester is served
//********************

`timescale 1ns/1ns

module rr_sched #(
   parameter int IN_WIDTH  = 4,
   parameter int OUT_WIDTH = 2
) (
   input  logic                 clk,
   input  logic                 rstn,
   input  logic [IN_WIDTH-1:0]  req,
   input  logic                 advance,
   output logic [OUT_WIDTH-1:0] grant
);

   // index served most recently
   logic [OUT_WIDTH-1:0] last;

   // scan downwards from a full turn so the nearest requester after last wins
   always_comb begin
      int idx;
      grant = last;
      for (int k = IN_WIDTH; k >= 1; k--) begin
         idx = (int'(last) + k) % IN_WIDTH;
         if (req[idx]) begin
            grant = OUT_WIDTH'(idx);
         end
      end
   end

   // start so that index 0 has the first turn after reset
   always_ff @(posedge clk) begin
      if (!rstn) begin
         last <= OUT_WIDTH'(IN_WIDTH - 1);
      end else if (advance) begin
         last <= grant;
      end
   end

   // the owning router only advances when it actually moved an item
   a_advance_has_req : assert property (@(posedge clk) disable iff (!rstn)
      advance |-> (|req));

endmodule

//--- design/xbar_pkg.sv
//********************
// field types, channel structs and the interleave mode
// widths come from xbar_defines.svh
// mode encoding 3 is illegal and never stored
//********************

`include "xbar_defines.svh"

package xbar_pkg;

   typedef logic [`XBAR_ID_W-1:0]   axi_id_t;
   typedef logic [`XBAR_ADDR_W-1:0] axi_addr_t;
   typedef logic [`XBAR_DATA_W-1:0] axi_data_t;
   typedef logic [7:0]              axi_len_t;
   typedef logic [1:0]              axi_resp_t;

   // one read request on the AR channel
   typedef struct packed {
      axi_id_t   id;
      axi_addr_t addr;
      axi_len_t  len;
   } ar_req_t;

   // one read data beat on the R channel
   typedef struct packed {
      axi_id_t   id;
      axi_data_t data;
      axi_resp_t resp;
      logic      last;
   } r_beat_t;

   // number of active controllers used for line interleaving
   typedef enum logic [1:0] {
      MODE_ONE  = 2'd0,
      MODE_TWO  = 2'd1,
      MODE_FOUR = 2'd2
   } mem_mode_e;

endpackage

//--- design/xbar_defines.svh
//********************
// sizes and field widths of the read crossbar
// the interleave logic is written for exactly four controllers
// a source index and a controller index share the same width
// the return source is taken from the top XBAR_PORT_W bits of the ID
//********************

`ifndef XBAR_DEFINES_SVH
`define XBAR_DEFINES_SVH

// request sources (tiles and host port)
`define XBAR_NUM_SRC   4
// memory controller ports
`define XBAR_NUM_MEM   4

`define XBAR_ID_W      8
`define XBAR_ADDR_W    32
`define XBAR_DATA_W    64

// cache line offset, cleared on the outgoing address
`define XBAR_LINE_BITS 6

// width of a source or controller index
`define XBAR_PORT_W    2

`endif
